// File: dev_pkg.sv
package dev_pkg;

	//////////////////////////////
	// Types

	typedef logic [11:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [7:0]  byte_t;
	typedef logic [1:0]  func_t;
	typedef logic [1:0]  reg_t;
	typedef logic [1:0]  port_t;

	//////////////////////////////
	// Address map

	localparam int FUNC_LSB = 10;
	localparam int PORT_LSB = 4;
	// Register index and ROM word index share these bits
	localparam int WORD_LSB = 2;

	localparam func_t FUNC_ROM = 2'd0;
	localparam func_t FUNC_MPS = 2'd1;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Per-port registers
	localparam reg_t REG_DATA   = 2'd0;
	localparam reg_t REG_STATUS = 2'd1;
	localparam reg_t REG_CTRL   = 2'd2;

	localparam int STAT_RX_VALID = 0;
	localparam int STAT_TX_BUSY  = 1;
	localparam int STAT_OVERRUN  = 2;

	//////////////////////////////
	// Serial timing

	localparam int UART_PORT_NUM = 4;
	localparam int BAUD_DIV      = 16;
	localparam int BAUD_CNT_W    = $clog2(BAUD_DIV);

	typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;

	localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(BAUD_DIV - 1);
	// Half a bit after the start edge
	localparam baud_cnt_t BAUD_HALF = baud_cnt_t'(BAUD_DIV / 2 - 1);

	// Identification words
	localparam int    ROM_WORDS = 16;
	localparam data_t DEVICE_ID = 32'h5e1a_0004;
	localparam data_t ROM_INFO  = {8'h00, 16'(BAUD_DIV), 8'(UART_PORT_NUM)};

endpackage

// File: axil_func_demux.sv
module axil_func_demux (
	input  logic           clk_i,
	input  logic           rst_n_i,

	// Write address
	input  dev_pkg::addr_t s_awaddr_i,
	input  logic           s_awvalid_i,
	output logic           s_awready_o,
	// Write data
	input  dev_pkg::data_t s_wdata_i,
	input  logic           s_wvalid_i,
	output logic           s_wready_o,
	// Write response
	output logic [1:0]     s_bresp_o,
	output logic           s_bvalid_o,
	input  logic           s_bready_i,
	// Read address
	input  dev_pkg::addr_t s_araddr_i,
	input  logic           s_arvalid_i,
	output logic           s_arready_o,
	// Read data
	output dev_pkg::data_t s_rdata_o,
	output logic [1:0]     s_rresp_o,
	output logic           s_rvalid_o,
	input  logic           s_rready_i,

	// Local bus
	output logic           rom_req_o,
	output logic           mps_req_o,
	output logic           we_o,
	output dev_pkg::addr_t offset_o,
	output dev_pkg::data_t wdata_o,
	input  logic           rom_ack_i,
	input  dev_pkg::data_t rom_rdata_i,
	input  logic           mps_ack_i,
	input  dev_pkg::data_t mps_rdata_i
);

	typedef enum logic [1:0] {
		AXIL_IDLE,
		AXIL_REQ,
		AXIL_RESP
	} axil_state_t;

	axil_state_t    state_q;
	logic           aw_held_q;
	logic           w_held_q;
	logic           we_q;
	logic [1:0]     resp_q;
	dev_pkg::addr_t addr_q;
	dev_pkg::data_t wdata_q;
	dev_pkg::data_t rdata_q;
	dev_pkg::func_t func;
	logic           mapped;
	logic           func_ack;
	dev_pkg::data_t func_rdata;
	logic           aw_hs;
	logic           w_hs;
	logic           ar_hs;

	//////////////////////////////
	// Function decode

	assign func   = addr_q[dev_pkg::FUNC_LSB +: $bits(dev_pkg::func_t)];
	assign mapped = (func == dev_pkg::FUNC_ROM) || (func == dev_pkg::FUNC_MPS);

	assign func_ack   = (func == dev_pkg::FUNC_ROM) ? rom_ack_i : mps_ack_i;
	assign func_rdata = (func == dev_pkg::FUNC_ROM) ? rom_rdata_i : mps_rdata_i;

	assign rom_req_o = (state_q == AXIL_REQ) && (func == dev_pkg::FUNC_ROM);
	assign mps_req_o = (state_q == AXIL_REQ) && (func == dev_pkg::FUNC_MPS);
	assign we_o      = we_q;
	assign offset_o  = addr_q;
	assign wdata_o   = wdata_q;

	//////////////////////////////
	// Host channels

	assign s_awready_o = (state_q == AXIL_IDLE) && !aw_held_q;
	assign s_wready_o  = (state_q == AXIL_IDLE) && !w_held_q;
	// Reads wait while any part of a write is around
	assign s_arready_o = (state_q == AXIL_IDLE) && !aw_held_q && !w_held_q &&
		!s_awvalid_i && !s_wvalid_i;

	assign aw_hs = s_awvalid_i && s_awready_o;
	assign w_hs  = s_wvalid_i && s_wready_o;
	assign ar_hs = s_arvalid_i && s_arready_o;

	assign s_bvalid_o = (state_q == AXIL_RESP) && we_q;
	assign s_rvalid_o = (state_q == AXIL_RESP) && !we_q;
	assign s_bresp_o  = resp_q;
	assign s_rresp_o  = resp_q;
	assign s_rdata_o  = rdata_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q   <= AXIL_IDLE;
			aw_held_q <= 1'b0;
			w_held_q  <= 1'b0;
			we_q      <= 1'b0;
			resp_q    <= dev_pkg::RESP_OKAY;
		end else begin
			case (state_q)
				AXIL_IDLE: begin
					if (aw_hs)
						aw_held_q <= 1'b1;
					if (w_hs)
						w_held_q <= 1'b1;
					if (aw_held_q && w_held_q) begin
						aw_held_q <= 1'b0;
						w_held_q  <= 1'b0;
						we_q      <= 1'b1;
						state_q   <= AXIL_REQ;
					end else if (ar_hs) begin
						we_q    <= 1'b0;
						state_q <= AXIL_REQ;
					end
				end
				AXIL_REQ: begin
					if (!mapped) begin
						resp_q  <= dev_pkg::RESP_SLVERR;
						state_q <= AXIL_RESP;
					end else if (func_ack) begin
						resp_q  <= dev_pkg::RESP_OKAY;
						state_q <= AXIL_RESP;
					end
				end
				AXIL_RESP: begin
					if ((we_q && s_bready_i) || (!we_q && s_rready_i))
						state_q <= AXIL_IDLE;
				end
				default: state_q <= AXIL_IDLE;
			endcase
		end
	end

	// Address, write data and read data
	always_ff @(posedge clk_i) begin
		if (aw_hs)
			addr_q <= s_awaddr_i;
		else if (ar_hs)
			addr_q <= s_araddr_i;
		if (w_hs)
			wdata_q <= s_wdata_i;
		if (state_q == AXIL_REQ)
			rdata_q <= mapped ? func_rdata : '0;
	end

	a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o));

	a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

	a_req_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0({rom_req_o, mps_req_o}));

endmodule

// File: config_rom.sv
module config_rom (
	input  logic           clk_i,
	input  logic           rst_n_i,
	input  logic           req_i,
	input  dev_pkg::addr_t offset_i,
	output logic           ack_o,
	output dev_pkg::data_t rdata_o
);

	logic [$clog2(dev_pkg::ROM_WORDS)-1:0] word_idx;

	// Upper offset bits alias onto the same 16 words
	assign word_idx = offset_i[dev_pkg::WORD_LSB +: $clog2(dev_pkg::ROM_WORDS)];

	// One ack per request, writes included
	always_ff @(posedge clk_i) begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= req_i && !ack_o;
	end

	always_ff @(posedge clk_i) begin
		if (req_i) begin
			case (word_idx)
				4'd0:    rdata_o <= dev_pkg::DEVICE_ID;
				4'd1:    rdata_o <= dev_pkg::ROM_INFO;
				default: rdata_o <= '0;
			endcase
		end
	end

endmodule

// File: uart_port.sv
module uart_port (
	input  logic           clk_i,
	input  logic           rst_n_i,

	// Transmit
	input  logic           tx_start_i,
	input  dev_pkg::byte_t tx_byte_i,
	output logic           tx_busy_o,
	output logic           tx_o,

	// Receive
	input  logic           rx_i,
	input  logic           rx_take_i,
	output dev_pkg::byte_t rx_byte_o,
	output logic           rx_valid_o,
	output logic           overrun_o
);

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_t;

	uart_state_t        tx_state_q;
	dev_pkg::baud_cnt_t tx_baud_q;
	logic [2:0]         tx_bit_q;
	dev_pkg::byte_t     tx_shift_q;
	logic               tx_load;
	logic               tx_next;

	uart_state_t        rx_state_q;
	dev_pkg::baud_cnt_t rx_baud_q;
	logic [2:0]         rx_bit_q;
	dev_pkg::byte_t     rx_shift_q;
	logic               rx_meta_q;
	logic               rx_sync_q;
	logic               rx_prev_q;
	logic               rx_sample;
	logic               rx_done;

	//////////////////////////////
	// Transmitter

	assign tx_busy_o = (tx_state_q != UART_IDLE);
	assign tx_load   = (tx_state_q == UART_IDLE) && tx_start_i;
	assign tx_next   = (tx_state_q == UART_DATA) && (tx_baud_q == dev_pkg::BAUD_LAST) &&
		(tx_bit_q != 3'd7);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			tx_state_q <= UART_IDLE;
			tx_baud_q  <= '0;
			tx_bit_q   <= '0;
			tx_o       <= 1'b1;
		end else begin
			case (tx_state_q)
				UART_IDLE: begin
					if (tx_start_i) begin
						tx_baud_q  <= '0;
						tx_o       <= 1'b0;
						tx_state_q <= UART_START;
					end
				end
				UART_START: begin
					if (tx_baud_q == dev_pkg::BAUD_LAST) begin
						tx_baud_q  <= '0;
						tx_bit_q   <= '0;
						tx_o       <= tx_shift_q[0];
						tx_state_q <= UART_DATA;
					end else
						tx_baud_q <= tx_baud_q + 1'b1;
				end
				UART_DATA: begin
					if (tx_baud_q == dev_pkg::BAUD_LAST) begin
						tx_baud_q <= '0;
						if (tx_bit_q == 3'd7) begin
							tx_o       <= 1'b1;
							tx_state_q <= UART_STOP;
						end else begin
							tx_bit_q <= tx_bit_q + 1'b1;
							tx_o     <= tx_shift_q[1];
						end
					end else
						tx_baud_q <= tx_baud_q + 1'b1;
				end
				UART_STOP: begin
					if (tx_baud_q == dev_pkg::BAUD_LAST)
						tx_state_q <= UART_IDLE;
					else
						tx_baud_q <= tx_baud_q + 1'b1;
				end
				default: tx_state_q <= UART_IDLE;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk_i) begin
		if (tx_load)
			tx_shift_q <= tx_byte_i;
		else if (tx_next)
			tx_shift_q <= {1'b0, tx_shift_q[7:1]};
	end

	//////////////////////////////
	// Receiver

	assign rx_sample = (rx_state_q == UART_DATA) && (rx_baud_q == dev_pkg::BAUD_LAST);
	// Middle of the stop bit
	assign rx_done   = (rx_state_q == UART_STOP) && (rx_baud_q == dev_pkg::BAUD_LAST);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rx_meta_q  <= 1'b1;
			rx_sync_q  <= 1'b1;
			rx_prev_q  <= 1'b1;
			rx_state_q <= UART_IDLE;
			rx_baud_q  <= '0;
			rx_bit_q   <= '0;
			rx_valid_o <= 1'b0;
			overrun_o  <= 1'b0;
		end else begin
			rx_meta_q <= rx_i;
			rx_sync_q <= rx_meta_q;
			rx_prev_q <= rx_sync_q;

			case (rx_state_q)
				UART_IDLE: begin
					if (rx_prev_q && !rx_sync_q) begin
						rx_baud_q  <= '0;
						rx_state_q <= UART_START;
					end
				end
				UART_START: begin
					if (rx_baud_q == dev_pkg::BAUD_HALF) begin
						rx_baud_q <= '0;
						rx_bit_q  <= '0;
						// Line already high again means a glitch
						rx_state_q <= rx_sync_q ? UART_IDLE : UART_DATA;
					end else
						rx_baud_q <= rx_baud_q + 1'b1;
				end
				UART_DATA: begin
					if (rx_baud_q == dev_pkg::BAUD_LAST) begin
						rx_baud_q <= '0;
						rx_bit_q  <= rx_bit_q + 1'b1;
						if (rx_bit_q == 3'd7)
							rx_state_q <= UART_STOP;
					end else
						rx_baud_q <= rx_baud_q + 1'b1;
				end
				UART_STOP: begin
					if (rx_baud_q == dev_pkg::BAUD_LAST)
						rx_state_q <= UART_IDLE;
					else
						rx_baud_q <= rx_baud_q + 1'b1;
				end
				default: rx_state_q <= UART_IDLE;
			endcase

			if (rx_done) begin
				rx_valid_o <= 1'b1;
				overrun_o  <= (rx_valid_o || overrun_o) && !rx_take_i;
			end else if (rx_take_i) begin
				rx_valid_o <= 1'b0;
				overrun_o  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rx_sample)
			rx_shift_q <= {rx_sync_q, rx_shift_q[7:1]};
		if (rx_done)
			rx_byte_o <= rx_shift_q;
	end

	a_tx_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(tx_state_q == UART_IDLE) |-> tx_o);

endmodule

// File: mps_regs.sv
module mps_regs (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              req_i,
	input  logic                              we_i,
	input  dev_pkg::addr_t                    offset_i,
	input  dev_pkg::data_t                    wdata_i,
	output logic                              ack_o,
	output dev_pkg::data_t                    rdata_o,
	input  logic [dev_pkg::UART_PORT_NUM-1:0] uart_rx_i,
	output logic [dev_pkg::UART_PORT_NUM-1:0] uart_tx_o,
	output logic                              irq_o
);

	dev_pkg::port_t                    port_sel;
	dev_pkg::reg_t                     reg_sel;
	logic                              data_wr;
	logic                              accept;
	logic [dev_pkg::UART_PORT_NUM-1:0] ctrl_q;
	logic [dev_pkg::UART_PORT_NUM-1:0] tx_start;
	logic [dev_pkg::UART_PORT_NUM-1:0] tx_busy;
	logic [dev_pkg::UART_PORT_NUM-1:0] rx_take;
	logic [dev_pkg::UART_PORT_NUM-1:0] rx_valid;
	logic [dev_pkg::UART_PORT_NUM-1:0] overrun;
	dev_pkg::byte_t                    rx_byte [dev_pkg::UART_PORT_NUM];
	dev_pkg::data_t                    rd_word;

	//////////////////////////////
	// Register decode

	assign port_sel = offset_i[dev_pkg::PORT_LSB +: $bits(dev_pkg::port_t)];
	assign reg_sel  = offset_i[dev_pkg::WORD_LSB +: $bits(dev_pkg::reg_t)];
	assign data_wr  = we_i && (reg_sel == dev_pkg::REG_DATA);

	// DATA writes hold off until the transmitter is free
	assign accept = req_i && !ack_o && !(data_wr && tx_busy[port_sel]);

	always_comb begin
		rd_word = '0;
		case (reg_sel)
			dev_pkg::REG_DATA:
				rd_word = {24'h0, rx_byte[port_sel]};
			dev_pkg::REG_STATUS: begin
				rd_word[dev_pkg::STAT_RX_VALID] = rx_valid[port_sel];
				rd_word[dev_pkg::STAT_TX_BUSY]  = tx_busy[port_sel];
				rd_word[dev_pkg::STAT_OVERRUN]  = overrun[port_sel];
			end
			dev_pkg::REG_CTRL:
				rd_word[0] = ctrl_q[port_sel];
			default:
				rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o  <= 1'b0;
			ctrl_q <= '0;
		end else begin
			ack_o <= accept;
			if (accept && we_i && (reg_sel == dev_pkg::REG_CTRL))
				ctrl_q[port_sel] <= wdata_i[0];
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept)
			rdata_o <= rd_word;
	end

	//////////////////////////////
	// Serial ports

	for (genvar i = 0; i < dev_pkg::UART_PORT_NUM; i++) begin : g_port
		assign tx_start[i] = accept && data_wr && (port_sel == dev_pkg::port_t'(i));
		assign rx_take[i]  = accept && !we_i && (reg_sel == dev_pkg::REG_DATA) &&
			(port_sel == dev_pkg::port_t'(i));

		uart_port uart_port_i (
			.clk_i(clk_i),
			.rst_n_i(rst_n_i),
			.tx_start_i(tx_start[i]),
			.tx_byte_i(wdata_i[7:0]),
			.tx_busy_o(tx_busy[i]),
			.tx_o(uart_tx_o[i]),
			.rx_i(uart_rx_i[i]),
			.rx_take_i(rx_take[i]),
			.rx_byte_o(rx_byte[i]),
			.rx_valid_o(rx_valid[i]),
			.overrun_o(overrun[i])
		);
	end

	assign irq_o = |(rx_valid & ctrl_q);

	// An acknowledged DATA write leaves its port transmitting
	a_data_wr_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ack_o && data_wr |-> tx_busy[port_sel]);

endmodule

// File: device_top.sv
module device_top (
	input  logic                              clk_i,
	input  logic                              rst_n_i,

	// AXI4-Lite host port
	input  dev_pkg::addr_t                    s_awaddr_i,
	input  logic                              s_awvalid_i,
	output logic                              s_awready_o,
	input  dev_pkg::data_t                    s_wdata_i,
	input  logic                              s_wvalid_i,
	output logic                              s_wready_o,
	output logic [1:0]                        s_bresp_o,
	output logic                              s_bvalid_o,
	input  logic                              s_bready_i,
	input  dev_pkg::addr_t                    s_araddr_i,
	input  logic                              s_arvalid_i,
	output logic                              s_arready_o,
	output dev_pkg::data_t                    s_rdata_o,
	output logic [1:0]                        s_rresp_o,
	output logic                              s_rvalid_o,
	input  logic                              s_rready_i,

	// Serial pins
	input  logic [dev_pkg::UART_PORT_NUM-1:0] uart_rx_i,
	output logic [dev_pkg::UART_PORT_NUM-1:0] uart_tx_o,
	output logic                              irq_o
);

	logic           rom_req;
	logic           mps_req;
	logic           we;
	dev_pkg::addr_t offset;
	dev_pkg::data_t wdata;
	logic           rom_ack;
	dev_pkg::data_t rom_rdata;
	logic           mps_ack;
	dev_pkg::data_t mps_rdata;

	//////////////////////////////
	// Host bus and function decode

	axil_func_demux axil_func_demux_i (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.s_awaddr_i(s_awaddr_i),
		.s_awvalid_i(s_awvalid_i),
		.s_awready_o(s_awready_o),
		.s_wdata_i(s_wdata_i),
		.s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o),
		.s_bresp_o(s_bresp_o),
		.s_bvalid_o(s_bvalid_o),
		.s_bready_i(s_bready_i),
		.s_araddr_i(s_araddr_i),
		.s_arvalid_i(s_arvalid_i),
		.s_arready_o(s_arready_o),
		.s_rdata_o(s_rdata_o),
		.s_rresp_o(s_rresp_o),
		.s_rvalid_o(s_rvalid_o),
		.s_rready_i(s_rready_i),
		.rom_req_o(rom_req),
		.mps_req_o(mps_req),
		.we_o(we),
		.offset_o(offset),
		.wdata_o(wdata),
		.rom_ack_i(rom_ack),
		.rom_rdata_i(rom_rdata),
		.mps_ack_i(mps_ack),
		.mps_rdata_i(mps_rdata)
	);

	//////////////////////////////
	// Identification ROM

	config_rom rom_i (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.req_i(rom_req),
		.offset_i(offset),
		.ack_o(rom_ack),
		.rdata_o(rom_rdata)
	);

	//////////////////////////////
	// Multi-port serial controller

	mps_regs mps_regs_i (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.req_i(mps_req),
		.we_i(we),
		.offset_i(offset),
		.wdata_i(wdata),
		.ack_o(mps_ack),
		.rdata_o(mps_rdata),
		.uart_rx_i(uart_rx_i),
		.uart_tx_o(uart_tx_o),
		.irq_o(irq_o)
	);

endmodule

// File: tb_device_top.sv
module tb_device_top;

	localparam int TIMEOUT = 1000;
	localparam int POLL_LIMIT = 200;
	// AXI response codes
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	logic clk = 1'b0;
	logic rst_n;
	dev_pkg::addr_t awaddr;
	logic awvalid;
	logic awready;
	dev_pkg::data_t wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	dev_pkg::addr_t araddr;
	logic arvalid;
	logic arready;
	dev_pkg::data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [3:0] uart_rx;
	logic [3:0] uart_tx;
	logic irq;
	logic loop_en;

	integer seed;
	int pass_cnt;
	int fail_cnt;
	int test_pass_base;
	int test_fail_base;
	int frames_seen;

	always #50 clk = ~clk;

	// Serial loopback, idle line otherwise
	assign uart_rx = loop_en ? uart_tx : 4'hf;

	device_top i_dut (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.s_awaddr_i(awaddr),
		.s_awvalid_i(awvalid),
		.s_awready_o(awready),
		.s_wdata_i(wdata),
		.s_wvalid_i(wvalid),
		.s_wready_o(wready),
		.s_bresp_o(bresp),
		.s_bvalid_o(bvalid),
		.s_bready_i(bready),
		.s_araddr_i(araddr),
		.s_arvalid_i(arvalid),
		.s_arready_o(arready),
		.s_rdata_o(rdata),
		.s_rresp_o(rresp),
		.s_rvalid_o(rvalid),
		.s_rready_i(rready),
		.uart_rx_i(uart_rx),
		.uart_tx_o(uart_tx),
		.irq_o(irq)
	);

	//////////////////////////////
	// Reference model

	function automatic logic [31:0] exp_rom(input int idx);
		logic [31:0] w;
		w = 32'h0;
		if (idx == 0) begin
			w = dev_pkg::DEVICE_ID;
		end else if (idx == 1) begin
			w[7:0] = 8'(dev_pkg::UART_PORT_NUM);
			w[23:8] = 16'(dev_pkg::BAUD_DIV);
		end
		return w;
	endfunction

	// Start bit, data LSB first, stop bit
	function automatic logic [9:0] exp_frame(input logic [7:0] b);
		return {1'b1, b, 1'b0};
	endfunction

	// Function 1 window, port in bits 5:4, register in bits 3:2
	function automatic dev_pkg::addr_t reg_addr(input int port, input int r);
		return dev_pkg::addr_t'(32'h400 + port * 16 + r * 4);
	endfunction

	//////////////////////////////
	// Compare and report

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic start_test();
		test_pass_base = pass_cnt;
		test_fail_base = fail_cnt;
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d mismatches", name,
			pass_cnt - test_pass_base + fail_cnt - test_fail_base, fail_cnt - test_fail_base);
	endtask

	task automatic abort_run(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("Regression failed");
		$finish;
	endtask

	//////////////////////////////
	// Host bus

	task automatic axil_write(input dev_pkg::addr_t addr, input logic [31:0] data,
		output logic [1:0] resp);
		logic aw_done;
		logic w_done;
		logic aw_now;
		logic w_now;
		int cnt;
		@(negedge clk);
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wvalid = 1'b1;
		aw_done = 1'b0;
		w_done = 1'b0;
		cnt = 0;
		while (!(aw_done && w_done)) begin
			if (cnt == TIMEOUT)
				abort_run("write address and data handshake");
			// Readies seen here hold through the next rising edge
			aw_now = awvalid && awready;
			w_now = wvalid && wready;
			@(negedge clk);
			if (aw_now) begin
				awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_now) begin
				wvalid = 1'b0;
				w_done = 1'b1;
			end
			cnt++;
		end
		cnt = 0;
		while (bvalid !== 1'b1) begin
			if (cnt == TIMEOUT)
				abort_run("bvalid");
			@(negedge clk);
			cnt++;
		end
		resp = bresp;
		@(negedge clk);
	endtask

	task automatic axil_read(input dev_pkg::addr_t addr, output logic [31:0] data,
		output logic [1:0] resp);
		int cnt;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		cnt = 0;
		while (arready !== 1'b1) begin
			if (cnt == TIMEOUT)
				abort_run("read address handshake");
			@(negedge clk);
			cnt++;
		end
		@(negedge clk);
		arvalid = 1'b0;
		cnt = 0;
		while (rvalid !== 1'b1) begin
			if (cnt == TIMEOUT)
				abort_run("rvalid");
			@(negedge clk);
			cnt++;
		end
		data = rdata;
		resp = rresp;
		@(negedge clk);
	endtask

	// Poll STATUS until the given bit is set
	task automatic wait_status(input int port, input int bit_pos, input string what);
		logic [31:0] st;
		logic [1:0] resp;
		int cnt;
		cnt = 0;
		axil_read(reg_addr(port, 1), st, resp);
		while (!st[bit_pos]) begin
			if (cnt == POLL_LIMIT)
				abort_run(what);
			axil_read(reg_addr(port, 1), st, resp);
			cnt++;
		end
	endtask

	task automatic wait_irq_high();
		int cnt;
		cnt = 0;
		while (irq !== 1'b1) begin
			if (cnt == TIMEOUT)
				abort_run("irq_o to rise");
			@(negedge clk);
			cnt++;
		end
	endtask

	// Mid-bit samples of one frame on a tx pin
	task automatic sample_frame(input int port, input logic [7:0] b);
		logic [9:0] exp;
		int cnt;
		exp = exp_frame(b);
		cnt = 0;
		while (uart_tx[port] !== 1'b0) begin
			if (cnt == TIMEOUT)
				abort_run("start bit on uart_tx_o");
			@(negedge clk);
			cnt++;
		end
		repeat (dev_pkg::BAUD_DIV / 2) @(negedge clk);
		for (int i = 0; i < 10; i++) begin
			check_value($sformatf("uart_tx_o[%0d] bit %0d", port, i),
				32'(uart_tx[port]), 32'(exp[i]));
			if (i < 9)
				repeat (dev_pkg::BAUD_DIV) @(negedge clk);
		end
		frames_seen++;
	endtask

	//////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] rd;
		logic [1:0] resp;
		dev_pkg::byte_t b1;
		dev_pkg::byte_t b2;
		dev_pkg::byte_t tx_bytes [4];

		seed = 32'hfd49;
		pass_cnt = 0;
		fail_cnt = 0;
		frames_seen = 0;
		loop_en = 1'b0;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		start_test();
		@(negedge clk);
		check_value("s_bvalid_o", 32'(bvalid), 0);
		check_value("s_rvalid_o", 32'(rvalid), 0);
		check_value("irq_o", 32'(irq), 0);
		check_value("uart_tx_o", 32'(uart_tx), 32'hf);
		check_value("s_awready_o", 32'(awready), 1);
		check_value("s_wready_o", 32'(wready), 1);
		check_value("s_arready_o", 32'(arready), 1);
		end_test("reset state");

		start_test();
		for (int i = 0; i < 16; i++) begin
			axil_read(dev_pkg::addr_t'(i * 4), rd, resp);
			check_value($sformatf("rom word %0d", i), rd, exp_rom(i));
			check_value("s_rresp_o", 32'(resp), 32'(OKAY));
		end
		axil_write(12'h000, 32'hdead_beef, resp);
		check_value("s_bresp_o", 32'(resp), 32'(OKAY));
		axil_read(12'h000, rd, resp);
		check_value("rom word 0", rd, exp_rom(0));
		end_test("rom read");

		start_test();
		for (int f = 2; f < 4; f++) begin
			axil_read(dev_pkg::addr_t'(f * 1024), rd, resp);
			check_value("s_rresp_o", 32'(resp), 32'(SLVERR));
			axil_write(dev_pkg::addr_t'(f * 1024 + 4), 32'h1234, resp);
			check_value("s_bresp_o", 32'(resp), 32'(SLVERR));
		end
		end_test("unmapped functions");

		start_test();
		for (int p = 0; p < 4; p++) begin
			b1 = dev_pkg::byte_t'($random(seed));
			b2 = dev_pkg::byte_t'($random(seed));
			frames_seen = 0;
			fork
				begin
					sample_frame(p, b1);
					sample_frame(p, b2);
				end
				begin
					axil_write(reg_addr(p, 0), {24'h0, b1}, resp);
					check_value("s_bresp_o", 32'(resp), 32'(OKAY));
					axil_read(reg_addr(p, 1), rd, resp);
					check_value("status tx_busy", 32'(rd[dev_pkg::STAT_TX_BUSY]), 1);
					// Held off until the first frame is out
					axil_write(reg_addr(p, 0), {24'h0, b2}, resp);
					check_value("s_bresp_o", 32'(resp), 32'(OKAY));
					check_value("frames before second bvalid", 32'(frames_seen), 1);
				end
			join
		end
		end_test("serial frame");

		start_test();
		loop_en = 1'b1;
		for (int p = 0; p < 4; p++) begin
			tx_bytes[p] = dev_pkg::byte_t'($random(seed));
			axil_write(reg_addr(p, 0), {24'h0, tx_bytes[p]}, resp);
		end
		for (int p = 0; p < 4; p++) begin
			wait_status(p, dev_pkg::STAT_RX_VALID, "rx_valid in STATUS");
			axil_read(reg_addr(p, 0), rd, resp);
			check_value($sformatf("port %0d rx data", p), rd, {24'h0, tx_bytes[p]});
			axil_read(reg_addr(p, 1), rd, resp);
			check_value("status rx_valid", 32'(rd[dev_pkg::STAT_RX_VALID]), 0);
		end
		b1 = dev_pkg::byte_t'($random(seed));
		b2 = dev_pkg::byte_t'($random(seed));
		axil_write(reg_addr(2, 0), {24'h0, b1}, resp);
		axil_write(reg_addr(2, 0), {24'h0, b2}, resp);
		wait_status(2, dev_pkg::STAT_OVERRUN, "overrun in STATUS");
		axil_read(reg_addr(2, 1), rd, resp);
		check_value("status rx_valid", 32'(rd[dev_pkg::STAT_RX_VALID]), 1);
		axil_read(reg_addr(2, 0), rd, resp);
		check_value("port 2 rx data", rd, {24'h0, b2});
		axil_read(reg_addr(2, 1), rd, resp);
		check_value("status overrun", 32'(rd[dev_pkg::STAT_OVERRUN]), 0);
		end_test("loopback receive");

		start_test();
		axil_write(reg_addr(3, 2), 32'h1, resp);
		axil_read(reg_addr(3, 2), rd, resp);
		check_value("ctrl", rd, 32'h1);
		check_value("irq_o", 32'(irq), 0);
		b1 = dev_pkg::byte_t'($random(seed));
		axil_write(reg_addr(3, 0), {24'h0, b1}, resp);
		wait_irq_high();
		axil_read(reg_addr(3, 0), rd, resp);
		check_value("port 3 rx data", rd, {24'h0, b1});
		check_value("irq_o", 32'(irq), 0);
		// Enable cleared, so a new byte stays silent
		axil_write(reg_addr(3, 2), 32'h0, resp);
		b2 = dev_pkg::byte_t'($random(seed));
		axil_write(reg_addr(3, 0), {24'h0, b2}, resp);
		wait_status(3, dev_pkg::STAT_RX_VALID, "rx_valid in STATUS");
		check_value("irq_o", 32'(irq), 0);
		axil_read(reg_addr(3, 0), rd, resp);
		check_value("port 3 rx data", rd, {24'h0, b2});
		end_test("interrupt");

		$display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: src.f
dev_pkg.sv
axil_func_demux.sv
config_rom.sv
uart_port.sv
mps_regs.sv
device_top.sv
tb_device_top.sv

// File: Makefile
# Verilator build and run of the device testbench

VERILATOR ?= verilator
TOP       ?= tb_device_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
